// ==== dv/clock_gen.sv ====
module clock_gen (
	output logic clock,
	output logic rst
);

	timeunit 1ns;
	timeprecision 1ps;

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Reset covers the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

// ==== dv/frontend_tb.sv ====
module frontend_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import frontend_pkg::*;

	logic          clock;
	logic          rst;
	logic          dispatch_no_hazard;
	logic          branch_incorrect;
	logic [63:0]   redirect_pc;
	decoded_inst_t decoded;
	logic          iq_full;

	// Own copy of the program for the reference walk
	logic [31:0] prog [ROM_DEPTH];

	// Reference walk state
	logic [63:0]         exp_pc;
	logic [BR_IDX_W-1:0] exp_tag;
	logic                tag_known;
	logic                hold_check;
	logic                seen_full;
	int                  n_decoded = 0;
	int                  errors = 0;
	int                  timeouts = 0;
	integer              seed;

	// Expected values for whatever sits on decoded
	logic [63:0] exp_npc;
	logic [63:0] dec_pc;
	logic [31:0] dec_word;
	op_class_e   exp_class;
	logic        exp_is_br;
	logic        exp_taken;
	logic [63:0] exp_target;
	logic [23:0] exp_fields;
	logic [23:0] dec_fields;
	logic [2:0]  exp_kind;
	logic [2:0]  dec_kind;

	clock_gen clock_gen_i (
		.clock (clock),
		.rst   (rst)
	);

	frontend_top frontend_top_i (
		.clock              (clock),
		.rst                (rst),
		.dispatch_no_hazard (dispatch_no_hazard),
		.branch_incorrect   (branch_incorrect),
		.redirect_pc        (redirect_pc),
		.decoded            (decoded),
		.iq_full            (iq_full)
	);

	function automatic op_class_e class_of(input logic [31:0] w);
		case (w[31:26])
			OP_INTA: class_of = CLASS_ALU;
			OP_LDQ: class_of = CLASS_LOAD;
			OP_STQ: class_of = CLASS_STORE;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: class_of = CLASS_COND_BR;
			OP_BR, OP_BSR: class_of = CLASS_UNCOND_BR;
			OP_JMP: class_of = CLASS_JUMP;
			default: class_of = CLASS_ILLEGAL;
		endcase
	endfunction

	// Static rule: unconditional taken, conditional taken when backward
	function automatic logic taken_of(input logic [31:0] w);
		case (w[31:26])
			OP_BR, OP_BSR: taken_of = 1'b1;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: taken_of = w[20];
			default: taken_of = 1'b0;
		endcase
	endfunction

	// Branch kind as {cond, direct, ret}
	function automatic logic [2:0] kind_of(input logic [31:0] w);
		case (w[31:26])
			OP_BR, OP_BSR: kind_of = 3'b010;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: kind_of = 3'b110;
			OP_JMP: kind_of = 3'b001;
			default: kind_of = 3'b000;
		endcase
	endfunction

	// Displacement counts words from the following instruction
	function automatic logic [63:0] target_of(input logic [63:0] pc, input logic [31:0] w);
		target_of = pc + 64'd4 + {{41{w[20]}}, w[20:0], 2'b00};
	endfunction

	// ra, rb, rc, literal flag and literal as the ISA lays them out
	function automatic logic [23:0] fields_of(input logic [31:0] w);
		logic [4:0] rb;
		logic [4:0] rc;
		logic       lit_en;
		logic [7:0] lit;
		rb = w[20:16];
		rc = 5'd31;
		lit_en = 1'b0;
		lit = 8'h0;
		case (w[31:26])
			OP_INTA: begin
				rc = w[4:0];
				if (w[12]) begin
					rb = 5'd31;
					lit_en = 1'b1;
					lit = w[20:13];
				end
			end
			OP_BR, OP_BSR, OP_BEQ, OP_BNE, OP_BLT, OP_BGE: rb = 5'd31;
			default: rb = w[20:16];
		endcase
		fields_of = {w[25:21], rb, rc, lit_en, lit};
	endfunction

	function automatic logic [63:0] walk_next(input logic [63:0] pc);
		logic [31:0] w;
		w = prog[pc[ROM_AW+1:2]];
		walk_next = taken_of(w) ? target_of(pc, w) : pc + 64'd4;
	endfunction

	assign exp_npc    = exp_pc + 64'd4;
	// Decode checks look up the word behind the npc that came out
	assign dec_pc     = decoded.npc - 64'd4;
	assign dec_word   = prog[dec_pc[ROM_AW+1:2]];
	assign exp_class  = class_of(dec_word);
	assign exp_is_br  = exp_class inside {CLASS_COND_BR, CLASS_UNCOND_BR, CLASS_JUMP};
	assign exp_taken  = taken_of(dec_word);
	assign exp_target = target_of(dec_pc, dec_word);
	assign exp_fields = fields_of(dec_word);
	assign exp_kind   = kind_of(dec_word);
	assign dec_fields = {decoded.ra, decoded.rb, decoded.rc, decoded.lit_en, decoded.lit};
	assign dec_kind   = {decoded.branch_inst.cond, decoded.branch_inst.direct,
		decoded.branch_inst.ret};

	// Reference PC walk, restarted by reset and by a flush
	always @(posedge clock) begin
		if (!rst && decoded.valid) begin
			n_decoded <= n_decoded + 1;
		end
		if (rst) begin
			exp_pc <= 64'h0;
			// Tag counter starts from zero out of reset
			exp_tag <= '0;
			tag_known <= 1'b1;
			seen_full <= 1'b0;
		end else if (branch_incorrect) begin
			exp_pc <= redirect_pc;
			// First tag after the flush sets the new expectation
			tag_known <= 1'b0;
		end else if (decoded.valid) begin
			exp_pc <= walk_next(exp_pc);
			if (decoded.branch_inst.en) begin
				exp_tag <= BR_IDX_W'((int'(decoded.branch_inst.br_idx) + 1) % OBQ_SIZE);
				tag_known <= 1'b1;
			end
		end
		if (hold_check && iq_full) begin
			seen_full <= 1'b1;
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		errors++;
		$display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
	endtask

	reset_full_a: assert property (@(posedge clock) rst |=> !iq_full)
		else report_mismatch("iq_full", $sampled(iq_full), 64'h0);
	reset_valid_a: assert property (@(posedge clock) rst |=> !decoded.valid)
		else report_mismatch("decoded.valid", $sampled(decoded.valid), 64'h0);

	order_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid |-> decoded.npc == exp_npc)
		else report_mismatch("decoded.npc", $sampled(decoded.npc), $sampled(exp_npc));

	hold_a: assert property (@(posedge clock) disable iff (rst)
		hold_check |-> !decoded.valid)
		else report_mismatch("decoded.valid", $sampled(decoded.valid), 64'h0);

	class_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid |-> decoded.op_class == exp_class)
		else report_mismatch("decoded.op_class", $sampled(decoded.op_class),
			$sampled(exp_class));

	fields_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid |-> dec_fields == exp_fields)
		else report_mismatch("decoded.{ra,rb,rc,lit_en,lit}", $sampled(dec_fields),
			$sampled(exp_fields));

	br_en_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid |-> decoded.branch_inst.en == exp_is_br)
		else report_mismatch("branch_inst.en", $sampled(decoded.branch_inst.en),
			$sampled(exp_is_br));

	br_kind_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid && decoded.branch_inst.en |-> dec_kind == exp_kind)
		else report_mismatch("branch_inst.{cond,direct,ret}", $sampled(dec_kind),
			$sampled(exp_kind));

	// Branch PC comes from the reference walk
	br_pc_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid && decoded.branch_inst.en |-> decoded.branch_inst.pc == exp_pc)
		else report_mismatch("branch_inst.pc", $sampled(decoded.branch_inst.pc),
			$sampled(exp_pc));

	pred_pc_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid && decoded.branch_inst.en |-> decoded.branch_inst.pred_pc == exp_target)
		else report_mismatch("branch_inst.pred_pc", $sampled(decoded.branch_inst.pred_pc),
			$sampled(exp_target));

	prediction_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid && decoded.branch_inst.en |-> decoded.branch_inst.prediction == exp_taken)
		else report_mismatch("branch_inst.prediction",
			$sampled(decoded.branch_inst.prediction), $sampled(exp_taken));

	br_idx_a: assert property (@(posedge clock) disable iff (rst)
		decoded.valid && decoded.branch_inst.en && tag_known |->
			decoded.branch_inst.br_idx == exp_tag)
		else report_mismatch("branch_inst.br_idx", $sampled(decoded.branch_inst.br_idx),
			$sampled(exp_tag));

	task automatic wait_reset_release(input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (rst && cycles < limit);
		if (rst) begin
			timeouts++;
			$display("Timeout: reset still asserted after %0d cycles", limit);
		end
	endtask

	// Runs until count more instructions are decoded, optionally with random hazards
	task automatic run_decodes(input int count, input logic rand_dispatch, input int limit);
		int start;
		int cycles;
		start = n_decoded;
		cycles = 0;
		while ((n_decoded - start) < count && cycles < limit) begin
			if (rand_dispatch) begin
				dispatch_no_hazard <= ($random(seed) & 3) != 0;
			end
			@(posedge clock);
			cycles++;
		end
		if ((n_decoded - start) < count) begin
			timeouts++;
			$display("Timeout: only %0d of %0d instructions decoded within %0d cycles",
				n_decoded - start, count, limit);
		end
	endtask

	initial begin
		seed = 32'h46bc_a8dd;
		dispatch_no_hazard = 1'b1;
		branch_incorrect = 1'b0;
		redirect_pc = 64'h0;
		hold_check = 1'b0;
		$readmemh("program.hex", prog);
		wait_reset_release(10);

		// Straight stream, then random dispatch hazards
		run_decodes(24, 1'b0, 200);
		run_decodes(40, 1'b1, 400);

		// Back-pressure for 20 cycles, decoded drains within two edges
		dispatch_no_hazard <= 1'b0;
		repeat (2) @(posedge clock);
		hold_check <= 1'b1;
		repeat (18) @(posedge clock);
		dispatch_no_hazard <= 1'b1;
		hold_check <= 1'b0;
		run_decodes(20, 1'b0, 200);
		full_seen_a: assert (seen_full) else begin
			errors++;
			$display("FAILED at %0t: iq_full never rose while dispatch was held", $time);
		end

		// Flush onto the JMP, then random hazards
		branch_incorrect <= 1'b1;
		redirect_pc <= 64'h18;
		@(posedge clock);
		branch_incorrect <= 1'b0;
		run_decodes(30, 1'b1, 400);

		// Flush with a full queue
		dispatch_no_hazard <= 1'b0;
		repeat (12) @(posedge clock);
		branch_incorrect <= 1'b1;
		redirect_pc <= 64'h20;
		dispatch_no_hazard <= 1'b1;
		@(posedge clock);
		branch_incorrect <= 1'b0;
		run_decodes(20, 1'b0, 200);

		$display("Errors: %0d, timeouts: %0d, instructions decoded: %0d",
			errors, timeouts, n_decoded);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
source/frontend_pkg.sv
source/fetch_pc_gen.sv
source/inst_rom.sv
source/branch_predecode.sv
source/inst_queue.sv
source/inst_decoder.sv
source/frontend_top.sv
dv/clock_gen.sv
dv/frontend_tb.sv

// ==== program.hex ====
// One 32-bit instruction word per line, in address order
// Line n holds the word at byte address 4*n
40220403
4080B405
A4C70008
E4200001
B4C70010
C3E00002
6BFB0000
4109040A
407FF40B
D3400001
40210401
F8600000
F49FFFF3
B45E0000

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the front-end testbench, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module frontend_tb -Mdir obj_dir -f filelist.f \
	&& ./obj_dir/Vfrontend_tb > sim.log 2>&1 \
	|| echo "TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0

// ==== source/branch_predecode.sv ====
module branch_predecode (
	input  logic                  clock,
	input  logic                  br_tag_rst,
	input  logic [31:0]           rom_word,
	input  logic [63:0]           rom_pc,
	input  logic                  rom_valid,
	output frontend_pkg::inst_q_t if_inst,
	output logic                  fetch_valid,
	output logic                  pred_taken,
	output logic [63:0]           pred_target
);

	import frontend_pkg::*;

	alpha_opcode_e       opcode;
	logic [20:0]         disp;
	logic [63:0]         npc;
	logic [63:0]         target;
	branch_info_t        br_info;
	// Next branch tag to hand out
	logic [BR_IDX_W-1:0] br_tag;

	assign opcode = alpha_opcode_e'(rom_word[31:26]);
	assign disp   = rom_word[20:0];
	assign npc    = rom_pc + 64'd4;

	// Branch displacement counts words from npc
	assign target = npc + {{41{disp[20]}}, disp, 2'b00};

	always_comb begin
		br_info = '0;
		case (opcode)
			// Unconditional direct, always taken
			OP_BR, OP_BSR: begin
				br_info.en         = 1'b1;
				br_info.direct     = 1'b1;
				br_info.prediction = 1'b1;
			end
			// Backward taken, forward not taken
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: begin
				br_info.en         = 1'b1;
				br_info.cond       = 1'b1;
				br_info.direct     = 1'b1;
				br_info.prediction = disp[20];
			end
			// Indirect group, target unknown here so fall through
			OP_JMP: begin
				br_info.en  = 1'b1;
				br_info.ret = 1'b1;
			end
			default: begin
				br_info = '0;
			end
		endcase
		if (br_info.en) begin
			br_info.pc      = rom_pc;
			br_info.pred_pc = target;
			br_info.br_idx  = br_tag;
		end
	end

	assign if_inst = '{
		valid_inst:  rom_valid,
		npc:         npc,
		ir:          rom_word,
		branch_inst: br_info
	};

	assign fetch_valid = rom_valid;
	assign pred_taken  = rom_valid & br_info.en & br_info.prediction;
	assign pred_target = target;

	// Tag counter wraps at OBQ_SIZE
	always_ff @(posedge clock) begin
		if (br_tag_rst) begin
			br_tag <= '0;
		end else if (rom_valid && br_info.en) begin
			if (br_tag == BR_IDX_W'(OBQ_SIZE - 1)) begin
				br_tag <= '0;
			end else begin
				br_tag <= br_tag + 1'b1;
			end
		end
	end

endmodule

// ==== source/fetch_pc_gen.sv ====
module fetch_pc_gen (
	input  logic        clock,
	input  logic        rst,
	input  logic        iq_full,
	input  logic        branch_incorrect,
	input  logic [63:0] redirect_pc,
	input  logic        pred_taken,
	input  logic [63:0] pred_target,
	output logic [63:0] fetch_pc,
	output logic        fetch_req
);

	// Set one cycle after reset drops, so fetch starts at PC 0
	logic        fetch_on;
	logic [63:0] next_pc;

	// No fetch while the queue is nearly full
	// A taken prediction skips the wrong-path word after the branch
	// A redirect squashes the word fetched in the same cycle
	assign fetch_req = fetch_on & ~iq_full & ~pred_taken & ~branch_incorrect;

	always_comb begin
		next_pc = fetch_pc;
		// Misprediction redirect has top priority
		if (branch_incorrect) begin
			next_pc = redirect_pc;
		// Predicted target still steers under iq_full
		end else if (pred_taken) begin
			next_pc = pred_target;
		// Sequential only when this PC was really fetched
		end else if (fetch_req) begin
			next_pc = fetch_pc + 64'd4;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			fetch_pc <= 64'h0;
			fetch_on <= 1'b0;
		end else begin
			fetch_pc <= next_pc;
			fetch_on <= 1'b1;
		end
	end

	// Redirect and predicted targets must keep the PC on a word boundary
	pc_aligned_a: assert property (
		@(posedge clock) disable iff (rst)
		fetch_pc[1:0] == 2'b00
	) else $error("fetch_pc not word aligned: %h", fetch_pc);

endmodule

// ==== source/frontend_pkg.sv ====
package frontend_pkg;

	// Instruction queue depth in packets
	localparam int IQ_SIZE = 10;
	// Occupancy counter must also hold the value IQ_SIZE
	localparam int IQ_CNT_W = $clog2(IQ_SIZE + 1);

	// Branch tags come from a wrapping order index
	localparam int OBQ_SIZE = 8;
	localparam int BR_IDX_W = $clog2(OBQ_SIZE);

	// Instruction ROM, word addressed
	localparam int ROM_DEPTH = 64;
	localparam int ROM_AW = $clog2(ROM_DEPTH);

	// addq r31, r31, r31
	localparam logic [31:0] NOOP_INST = 32'h43ff_041f;

	// Major opcodes in ir[31:26]
	typedef enum logic [5:0] {
		OP_INTA = 6'h10,
		OP_JMP  = 6'h1a,
		OP_LDQ  = 6'h29,
		OP_STQ  = 6'h2d,
		OP_BR   = 6'h30,
		OP_BSR  = 6'h34,
		OP_BEQ  = 6'h39,
		OP_BLT  = 6'h3a,
		OP_BNE  = 6'h3d,
		OP_BGE  = 6'h3e
	} alpha_opcode_e;

	typedef enum logic [2:0] {
		CLASS_ALU,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_COND_BR,
		CLASS_UNCOND_BR,
		CLASS_JUMP,
		CLASS_ILLEGAL
	} op_class_e;

	typedef struct packed {
		logic                en;
		logic                cond;
		logic                direct;
		logic                ret;
		logic [63:0]         pc;
		logic [63:0]         pred_pc;
		logic [BR_IDX_W-1:0] br_idx;
		logic                prediction;
	} branch_info_t;

	// One queue slot
	typedef struct packed {
		logic         valid_inst;
		logic [63:0]  npc;
		logic [31:0]  ir;
		branch_info_t branch_inst;
	} inst_q_t;

	// Empty slot, carries a noop
	localparam inst_q_t EMPTY_INST_Q = '{
		valid_inst:  1'b0,
		npc:         64'h0,
		ir:          NOOP_INST,
		branch_inst: '0
	};

	typedef struct packed {
		logic         valid;
		logic [63:0]  npc;
		op_class_e    op_class;
		logic [4:0]   ra;
		logic [4:0]   rb;
		logic [4:0]   rc;
		logic         lit_en;
		logic [7:0]   lit;
		branch_info_t branch_inst;
	} decoded_inst_t;

endpackage

// ==== source/frontend_top.sv ====
module frontend_top (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        dispatch_no_hazard,
	input  logic                        branch_incorrect,
	input  logic [63:0]                 redirect_pc,
	output frontend_pkg::decoded_inst_t decoded,
	output logic                        iq_full
);

	import frontend_pkg::*;

	// PC generator to ROM
	logic [63:0] fetch_pc;
	logic        fetch_req;

	// ROM to predecode
	logic [31:0] rom_word;
	logic        rom_valid;
	logic [63:0] rom_pc;

	// Predecode to queue and PC generator
	inst_q_t     if_inst;
	logic        fetch_valid;
	logic        pred_taken;
	logic [63:0] pred_target;

	// Queue head to decode
	inst_q_t     if_inst_out;

	fetch_pc_gen fetch_pc_gen_i (
		.clock            (clock),
		.rst              (rst),
		.iq_full          (iq_full),
		.branch_incorrect (branch_incorrect),
		.redirect_pc      (redirect_pc),
		.pred_taken       (pred_taken),
		.pred_target      (pred_target),
		.fetch_pc         (fetch_pc),
		.fetch_req        (fetch_req)
	);

	inst_rom inst_rom_i (
		.clock            (clock),
		.fetch_pc         (fetch_pc),
		.fetch_req        (fetch_req),
		.branch_incorrect (branch_incorrect),
		.rom_word         (rom_word),
		.rom_valid        (rom_valid),
		.rom_pc           (rom_pc)
	);

	// Tag counter restarts only with the core reset
	branch_predecode branch_predecode_i (
		.clock       (clock),
		.br_tag_rst  (rst),
		.rom_word    (rom_word),
		.rom_pc      (rom_pc),
		.rom_valid   (rom_valid),
		.if_inst     (if_inst),
		.fetch_valid (fetch_valid),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

	inst_queue inst_queue_i (
		.clock              (clock),
		.rst                (rst),
		.fetch_valid        (fetch_valid),
		.if_inst_in         (if_inst),
		.dispatch_no_hazard (dispatch_no_hazard),
		.branch_incorrect   (branch_incorrect),
		.inst_queue_full    (iq_full),
		.if_inst_out        (if_inst_out)
	);

	inst_decoder inst_decoder_i (
		.clock            (clock),
		.rst              (rst),
		.branch_incorrect (branch_incorrect),
		.if_inst_out      (if_inst_out),
		.decoded          (decoded)
	);

endmodule

// ==== source/inst_decoder.sv ====
module inst_decoder (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        branch_incorrect,
	input  frontend_pkg::inst_q_t       if_inst_out,
	output frontend_pkg::decoded_inst_t decoded
);

	import frontend_pkg::*;

	alpha_opcode_e opcode;
	logic [31:0]   ir;
	decoded_inst_t dec_next;

	assign ir     = if_inst_out.ir;
	assign opcode = alpha_opcode_e'(ir[31:26]);

	always_comb begin
		dec_next             = '0;
		dec_next.valid       = if_inst_out.valid_inst;
		dec_next.npc         = if_inst_out.npc;
		dec_next.branch_inst = if_inst_out.branch_inst;
		// Default field layout, r31 where a field is unused
		dec_next.ra          = ir[25:21];
		dec_next.rb          = ir[20:16];
		dec_next.rc          = 5'd31;
		case (opcode)
			OP_INTA: begin
				dec_next.op_class = CLASS_ALU;
				dec_next.rc       = ir[4:0];
				// Literal form replaces rb with an 8-bit constant
				if (ir[12]) begin
					dec_next.lit_en = 1'b1;
					dec_next.lit    = ir[20:13];
					dec_next.rb     = 5'd31;
				end
			end
			OP_LDQ: begin
				dec_next.op_class = CLASS_LOAD;
			end
			OP_STQ: begin
				dec_next.op_class = CLASS_STORE;
			end
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: begin
				dec_next.op_class = CLASS_COND_BR;
				dec_next.rb       = 5'd31;
			end
			OP_BR, OP_BSR: begin
				dec_next.op_class = CLASS_UNCOND_BR;
				dec_next.rb       = 5'd31;
			end
			// Target register in rb
			OP_JMP: begin
				dec_next.op_class = CLASS_JUMP;
			end
			default: begin
				dec_next.op_class = CLASS_ILLEGAL;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		decoded <= dec_next;
		// Flush kills the instruction in flight
		if (rst || branch_incorrect) begin
			decoded.valid <= 1'b0;
		end
	end

	// Program in the ROM holds only recognized opcodes
	legal_class_a: assert property (
		@(posedge clock) disable iff (rst)
		decoded.valid |-> decoded.op_class != CLASS_ILLEGAL
	) else $error("illegal opcode decoded at npc %h", decoded.npc);

endmodule

// ==== source/inst_queue.sv ====
module inst_queue (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  fetch_valid,
	input  frontend_pkg::inst_q_t if_inst_in,
	input  logic                  dispatch_no_hazard,
	input  logic                  branch_incorrect,
	output logic                  inst_queue_full,
	output frontend_pkg::inst_q_t if_inst_out
);

	import frontend_pkg::*;

	// Slot 0 is the head, tail counts valid slots
	inst_q_t [IQ_SIZE-1:0] queue;
	inst_q_t [IQ_SIZE-1:0] next_queue;
	logic [IQ_CNT_W-1:0]   tail;
	logic [IQ_CNT_W-1:0]   next_tail;
	// Occupancy after both enqueue and dispatch
	logic [IQ_CNT_W-1:0]   out_tail;
	logic                  enq;
	logic                  deq;

	// Word arriving at a completely full queue is dropped
	assign enq = fetch_valid && (tail != IQ_CNT_W'(IQ_SIZE));
	// Dispatch only entries already stored
	assign deq = dispatch_no_hazard && (tail != '0);

	// Enqueue stage
	always_comb begin
		next_queue = queue;
		next_tail  = tail;
		if (enq) begin
			next_queue[tail] = if_inst_in;
			next_tail        = tail + 1'b1;
		end
		out_tail = deq ? next_tail - 1'b1 : next_tail;
	end

	// Dispatch stage, shifts the head out
	always_ff @(posedge clock) begin
		if (rst || branch_incorrect) begin
			for (int i = 0; i < IQ_SIZE; i++) begin
				queue[i] <= EMPTY_INST_Q;
			end
			tail            <= '0;
			inst_queue_full <= 1'b0;
			if_inst_out     <= EMPTY_INST_Q;
		end else begin
			tail <= out_tail;
			// Early full keeps one slot for the word already in the ROM
			inst_queue_full <= out_tail >= IQ_CNT_W'(IQ_SIZE - 1);
			if (deq) begin
				if_inst_out <= queue[0];
				for (int i = 0; i < IQ_SIZE - 1; i++) begin
					queue[i] <= next_queue[i + 1];
				end
				queue[IQ_SIZE-1] <= EMPTY_INST_Q;
			end else begin
				// Hazard or empty, nothing leaves
				if_inst_out <= EMPTY_INST_Q;
				queue       <= next_queue;
			end
		end
	end

	tail_bound_a: assert property (
		@(posedge clock) disable iff (rst)
		tail <= IQ_CNT_W'(IQ_SIZE)
	) else $error("queue tail %0d beyond IQ_SIZE", tail);

	// Early full and fetch stall together must leave room for every fetched word
	no_overflow_a: assert property (
		@(posedge clock) disable iff (rst)
		fetch_valid |-> tail != IQ_CNT_W'(IQ_SIZE)
	) else $error("enqueue dropped at full occupancy");

endmodule

// ==== source/inst_rom.sv ====
module inst_rom (
	input  logic        clock,
	input  logic [63:0] fetch_pc,
	input  logic        fetch_req,
	input  logic        branch_incorrect,
	output logic [31:0] rom_word,
	output logic        rom_valid,
	output logic [63:0] rom_pc
);

	import frontend_pkg::*;

	logic [31:0]       mem [ROM_DEPTH];
	logic [ROM_AW-1:0] word_addr;

	initial begin
		$readmemh("program.hex", mem);
	end

	// Byte PC to word index, upper bits wrap
	assign word_addr = fetch_pc[ROM_AW+1:2];

	always_ff @(posedge clock) begin
		// Word and its PC only load on a real fetch
		if (fetch_req) begin
			rom_word <= mem[word_addr];
			rom_pc   <= fetch_pc;
		end
		// Word fetched during a flush is stale
		rom_valid <= fetch_req & ~branch_incorrect;
	end

endmodule
